/* logic/la_mem_settings.svh */
// memory geometry and read-register macros shared by the wishbone RAM blocks
`ifndef LA_MEM_SETTINGS_SVH
`define LA_MEM_SETTINGS_SVH

// data word width in bits
`define LA_MEM_DW 32

// number of words in the array
`define LA_MEM_DEPTH 64

// word address width, log2 of depth
`define LA_MEM_AW 6

// 1 = registered RAM read, 0 = combinational read
`define LA_MEM_REG 1

`endif

/* logic/la_mem_pkg.sv */
// package with wishbone request/response and RAM write/read command structs
`include "la_mem_settings.svh"

package la_mem_pkg;

   // wishbone classic request, master to slave
   typedef struct packed {
      logic                    cyc;   // bus cycle active
      logic                    stb;   // strobe, request valid
      logic                    we;    // 1 = write
      logic [`LA_MEM_DW/8-1:0] sel;   // byte selects
      logic [`LA_MEM_AW-1:0]   adr;   // word index, not byte address
      logic [`LA_MEM_DW-1:0]   dat;   // write data
   } wb_req_t;

   // wishbone classic response, slave to master
   typedef struct packed {
      logic                  ack;     // one cycle per access
      logic [`LA_MEM_DW-1:0] dat;     // read data
   } wb_rsp_t;

   // RAM write port command
   typedef struct packed {
      logic                  ce;      // write chip enable
      logic                  we;      // write enable
      logic [`LA_MEM_DW-1:0] wmask;   // per-bit write mask
      logic [`LA_MEM_AW-1:0] addr;    // word address
      logic [`LA_MEM_DW-1:0] din;     // write data
   } ram_wr_t;

   // RAM read port command
   typedef struct packed {
      logic                  ce;      // read chip enable, loads read reg
      logic [`LA_MEM_AW-1:0] addr;    // word address
   } ram_rd_t;

endpackage

/* logic/la_dpram.sv */
// la_dpram soft dual-port RAM with per-bit write mask and optional read register
`include "la_mem_settings.svh"

module la_dpram #(
   parameter int DW    = `LA_MEM_DW,     // word width
   parameter int DEPTH = `LA_MEM_DEPTH,  // number of words
   parameter int REG   = `LA_MEM_REG     // 1 adds output register stage
) (
   input  logic                clk,      // common clock
   input  la_mem_pkg::ram_wr_t wr,       // write port command
   input  la_mem_pkg::ram_rd_t rd,       // read port command
   output logic [DW-1:0]       rd_dout   // read data out
);

   logic [DW-1:0] mem [DEPTH];           // storage, no defined power-up contents
   logic [DW-1:0] rdata;                 // raw array read

   // write port, each bit gated by its own mask bit
   always_ff @(posedge clk) begin
      for (int i = 0; i < DW; i++) begin
         if (wr.ce && wr.we && wr.wmask[i]) begin
            mem[wr.addr][i] <= wr.din[i];
         end
      end
   end

   // read port, asynchronous array lookup
   // same-address write in this cycle still shows old word
   assign rdata = mem[rd.addr];

   generate
      if (REG == 1) begin : g_rd_reg
         logic [DW-1:0] rd_q;            // output pipeline stage

         always_ff @(posedge clk) begin
            if (rd.ce) begin             // holds last read when idle
               rd_q <= rdata;
            end
         end

         assign rd_dout = rd_q;
      end else begin : g_rd_comb
         assign rd_dout = rdata;         // bypass, data follows rd.addr
      end
   endgenerate

endmodule

/* logic/la_mem_clear.sv */
// la_mem_clear post-reset sweep that zeroes every RAM word and flags done
`include "la_mem_settings.svh"

module la_mem_clear (
   input  logic                clk,
   input  logic                rst,      // sync, active high
   output la_mem_pkg::ram_wr_t clr_wr,   // zero-fill write command
   output logic                done      // high once all words cleared
);

   localparam int AW    = `LA_MEM_AW;
   localparam int DW    = `LA_MEM_DW;
   localparam logic [AW-1:0] LAST = AW'(`LA_MEM_DEPTH - 1);  // final address

   logic          busy;                  // sweep in progress
   logic [AW-1:0] addr;                  // sweep address counter

   // arm in first cycle out of reset, then one word per clock
   always_ff @(posedge clk) begin
      if (rst) begin
         busy <= 1'b0;
         done <= 1'b0;
         addr <= '0;
      end else if (!busy && !done) begin
         busy <= 1'b1;                   // start sweep at address 0
      end else if (busy) begin
         addr <= addr + 1'b1;            // wraps to 0 after last word
         if (addr == LAST) begin
            busy <= 1'b0;
            done <= 1'b1;                // sticky until next reset
         end
      end
   end

   // full-mask zero write, live only while sweeping
   always_comb begin
      clr_wr.ce    = busy;
      clr_wr.we    = busy;
      clr_wr.wmask = {DW{1'b1}};
      clr_wr.addr  = addr;
      clr_wr.din   = '0;
   end

endmodule

/* logic/la_wb_ram_bridge.sv */
// la_wb_ram_bridge wishbone classic slave to RAM command bridge with clear mux and ack
`include "la_mem_settings.svh"

module la_wb_ram_bridge (
   input  logic                        clk,
   input  logic                        rst,      // sync, active high
   input  la_mem_pkg::wb_req_t         req,      // from bus master
   output la_mem_pkg::wb_rsp_t         rsp,      // to bus master
   input  la_mem_pkg::ram_wr_t         clr_wr,   // write from clear engine
   input  logic                        done,     // clear engine finished
   output la_mem_pkg::ram_wr_t         ram_wr,   // to RAM write port
   output la_mem_pkg::ram_rd_t         ram_rd,   // to RAM read port
   input  logic [`LA_MEM_DW-1:0]       rd_dout   // RAM read data
);

   import la_mem_pkg::*;

   localparam int DW  = `LA_MEM_DW;
   localparam int NB  = DW / 8;          // bytes per word
   localparam int REG = `LA_MEM_REG;

   logic          accept;                // request sampled this cycle
   logic          ack_q;                 // registered ack
   logic [DW-1:0] mask;                  // byte selects widened to bits
   ram_wr_t       bus_wr;                // write command from bus side

   // one access in flight, nothing taken during clear
   assign accept = done & req.cyc & req.stb & ~ack_q;

   // sel bit n covers data bits 8n+7..8n
   always_comb begin
      for (int b = 0; b < NB; b++) begin
         mask[b*8 +: 8] = {8{req.sel[b]}};
      end
   end

   // bus write, issued in the sample cycle only
   always_comb begin
      bus_wr.ce    = accept & req.we;
      bus_wr.we    = req.we;
      bus_wr.wmask = mask;
      bus_wr.addr  = req.adr;
      bus_wr.din   = req.dat;
   end

   // clear engine owns write port until done
   assign ram_wr = done ? bus_wr : clr_wr;

   // read command, also only in the sample cycle
   assign ram_rd.ce   = accept & ~req.we;
   assign ram_rd.addr = req.adr;

   // ack one cycle after sample, never back to back
   always_ff @(posedge clk) begin
      if (rst) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= accept;
      end
   end

   assign rsp.ack = ack_q;

   generate
      if (REG == 1) begin : g_dat_ram
         // RAM read register already lines up with ack
         assign rsp.dat = rd_dout;
      end else begin : g_dat_cap
         logic [DW-1:0] rdat_q;          // captured combinational read

         always_ff @(posedge clk) begin
            if (accept && !req.we) begin
               rdat_q <= rd_dout;        // addr valid in sample cycle
            end
         end

         assign rsp.dat = rdat_q;
      end
   endgenerate

endmodule

/* logic/la_wb_ram.sv */
// la_wb_ram top level joining wishbone bridge, clear engine and dual-port RAM
`include "la_mem_settings.svh"

module la_wb_ram (
   input  logic                clk,
   input  logic                rst,      // sync, active high
   input  la_mem_pkg::wb_req_t req,      // wishbone request
   output la_mem_pkg::wb_rsp_t rsp       // wishbone response
);

   import la_mem_pkg::*;

   ram_wr_t               clr_wr;        // clear engine write
   logic                  done;          // clear finished
   ram_wr_t               ram_wr;        // muxed write into RAM
   ram_rd_t               ram_rd;        // read command into RAM
   logic [`LA_MEM_DW-1:0] rd_dout;       // RAM read data

   // zero fill after reset
   la_mem_clear u_clear (
      .clk    (clk),
      .rst    (rst),
      .clr_wr (clr_wr),
      .done   (done)
   );

   // bus slave, holds off requests until done
   la_wb_ram_bridge u_bridge (
      .clk     (clk),
      .rst     (rst),
      .req     (req),
      .rsp     (rsp),
      .clr_wr  (clr_wr),
      .done    (done),
      .ram_wr  (ram_wr),
      .ram_rd  (ram_rd),
      .rd_dout (rd_dout)
   );

   // storage
   la_dpram #(
      .DW    (`LA_MEM_DW),
      .DEPTH (`LA_MEM_DEPTH),
      .REG   (`LA_MEM_REG)
   ) u_ram (
      .clk     (clk),
      .wr      (ram_wr),
      .rd      (ram_rd),
      .rd_dout (rd_dout)
   );

endmodule

/* dv/la_wb_ram_assert.sv */
// la_wb_ram_assert wishbone handshake assertions bound into the RAM top level
module la_wb_ram_assert (
   input logic                clk,
   input logic                rst,     // sync, active high
   input la_mem_pkg::wb_req_t req,     // master request as seen by dut
   input la_mem_pkg::wb_rsp_t rsp      // slave response
);

   import la_mem_pkg::*;

   logic req_wait;                     // strobe out, ack not yet back

   assign req_wait = req.cyc & req.stb & ~rsp.ack;

   // single-cycle ack pulse
   ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
      rsp.ack |=> !rsp.ack)
      else $error("ack held high for two cycles");

   // ack only answers a live strobe
   ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
      rsp.ack |-> (req.cyc && req.stb))
      else $error("ack seen without cyc and stb");

   // master holds request fields from stb until ack
   req_stable: assert property (@(posedge clk) disable iff (rst)
      req_wait |=> (req.cyc && req.stb && $stable(req.we) && $stable(req.sel)
                    && $stable(req.adr) && $stable(req.dat)))
      else $error("request changed before ack");

endmodule

/* dv/la_wb_ram_tb.sv */
// la_wb_ram_tb clock, reset, wishbone tasks, reference model, compare process and tests
`include "la_mem_settings.svh"

module la_wb_ram_tb;

   import la_mem_pkg::*;

   localparam int DW      = `LA_MEM_DW;
   localparam int AW      = `LA_MEM_AW;
   localparam int DEPTH   = `LA_MEM_DEPTH;
   localparam int NB      = DW / 8;
   localparam int TIMEOUT = DEPTH + 10;   // first access waits out the clear

   typedef struct packed {
      logic [AW-1:0] adr;                 // address that was read
      logic [DW-1:0] dat;                 // data returned on the bus
   } rd_item_t;

   logic     clk;
   logic     rst;
   wb_req_t  req;
   wb_rsp_t  rsp;

   logic [DW-1:0] model [DEPTH];          // expected memory image
   rd_item_t      rd_q [$];               // reads waiting for compare
   event          rd_pushed;
   int            errors;
   int            checks;
   int            tests_failed;

   la_wb_ram dut (
      .clk (clk),
      .rst (rst),
      .req (req),
      .rsp (rsp)
   );

   bind la_wb_ram la_wb_ram_assert u_assert (
      .clk (clk),
      .rst (rst),
      .req (req),
      .rsp (rsp)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;            // period 100
   end

   // old word with selected bytes taken from the new data
   function automatic logic [DW-1:0] merge_word(input logic [DW-1:0] old_w,
                                                input logic [DW-1:0] new_w,
                                                input logic [NB-1:0] sel);
      logic [DW-1:0] w;
      w = old_w;
      for (int b = 0; b < NB; b++) begin
         if (sel[b]) w[8*b +: 8] = new_w[8*b +: 8];   // byte b replaced
      end
      return w;
   endfunction

   task automatic check_value(input string name, input logic [DW-1:0] exp,
                              input logic [DW-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("MISMATCH %s expected 0x%h actual 0x%h", name, exp, act);
      end
   endtask

   task automatic finish_run();
      $display("checks %0d, errors %0d, tests failed %0d", checks, errors, tests_failed);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   endtask

   // let the compare process catch up with queued reads
   task automatic drain_compare();
      int n;
      n = 0;
      while (rd_q.size() != 0 && n < 10) begin
         @(posedge clk);
         n++;
      end
      if (rd_q.size() != 0) begin
         $display("compare queue still holds %0d reads", rd_q.size());
         errors++;
      end
   endtask

   task automatic report_test(input int num, input string title, input int err_before);
      drain_compare();                   // last read of the test counted here
      if (errors == err_before) begin
         $display("test %0d %s: pass", num, title);
      end else begin
         tests_failed++;
         $display("test %0d %s: fail, %0d errors", num, title, errors - err_before);
      end
   endtask

   // one classic cycle, called and returning at a rising edge
   task automatic bus_access(input logic we, input logic [AW-1:0] adr,
                             input logic [NB-1:0] sel, input logic [DW-1:0] dat,
                             output logic [DW-1:0] rdat, output int lat);
      wb_req_t r;
      int      n;
      r     = '0;
      r.cyc = 1'b1;
      r.stb = 1'b1;
      r.we  = we;
      r.sel = sel;
      r.adr = adr;
      r.dat = dat;
      req <= r;
      n = 0;
      do begin
         @(posedge clk);                 // sees values of the cycle just ended
         n++;
      end while (!rsp.ack && n < TIMEOUT);
      if (!rsp.ack) begin
         $display("timeout: no ack for %s at address 0x%h", we ? "write" : "read", adr);
         errors++;
         finish_run();
      end else begin
         rdat = rsp.dat;
         lat  = n;
         req.cyc <= 1'b0;                // release bus in cycle after ack
         req.stb <= 1'b0;
         @(posedge clk);
         check_value("rsp.ack", '0, DW'(rsp.ack));   // ack gone after one cycle
      end
   endtask

   task automatic wb_write(input logic [AW-1:0] adr, input logic [NB-1:0] sel,
                           input logic [DW-1:0] dat, output int lat);
      logic [DW-1:0] unused;
      bus_access(1'b1, adr, sel, dat, unused, lat);
      model[adr] = merge_word(model[adr], dat, sel);
   endtask

   task automatic wb_read(input logic [AW-1:0] adr, output int lat);
      logic [DW-1:0] d;
      bus_access(1'b0, adr, '0, '0, d, lat);
      rd_q.push_back('{adr: adr, dat: d});
      -> rd_pushed;                      // compare runs before any later write
   endtask

   // compare each read against the model as it arrives
   initial begin : compare_proc
      rd_item_t it;
      forever begin
         @(rd_pushed);
         while (rd_q.size() != 0) begin
            it = rd_q.pop_front();
            check_value("rsp.dat", model[it.adr], it.dat);
         end
      end
   end

   initial begin : main
      int            e0;
      int            lat;
      logic [AW-1:0] a;
      logic [NB-1:0] s;
      void'($urandom(64));
      errors       = 0;
      checks       = 0;
      tests_failed = 0;
      rst          = 1'b1;
      req          = '0;
      for (int i = 0; i < DEPTH; i++) model[i] = '0;   // clear engine zero fill
      repeat (5) @(posedge clk);
      rst <= 1'b0;

      // 1 zero contents after reset
      e0 = errors;
      wb_read('0, lat);
      wb_read(AW'(DEPTH - 1), lat);
      repeat (6) wb_read(AW'($urandom % DEPTH), lat);
      report_test(1, "clear after reset", e0);

      // 2 full-word write then read back
      e0 = errors;
      for (int i = 0; i < DEPTH; i++) wb_write(AW'(i), '1, DW'($urandom), lat);
      for (int i = 0; i < DEPTH; i++) wb_read(AW'(i), lat);
      report_test(2, "full-word writes", e0);

      // 3 every sel pattern over a known word
      e0 = errors;
      for (int p = 0; p < (1 << NB); p++) begin
         a = AW'($urandom % DEPTH);
         wb_write(a, '1, DW'($urandom), lat);
         wb_write(a, NB'(p), DW'($urandom), lat);
         wb_read(a, lat);
      end
      report_test(3, "byte-select writes", e0);

      // 4 random mix
      e0 = errors;
      for (int i = 0; i < 300; i++) begin
         a = AW'($urandom % DEPTH);
         s = NB'($urandom);
         if ($urandom % 2) wb_write(a, s, DW'($urandom), lat);
         else wb_read(a, lat);
      end
      report_test(4, "random traffic", e0);

      // 5 two-cycle ack for writes and reads
      e0 = errors;
      for (int i = 0; i < 8; i++) begin
         a = AW'($urandom % DEPTH);
         wb_write(a, NB'($urandom), DW'($urandom), lat);
         check_value("ack latency", DW'(2), DW'(lat));
         wb_read(a, lat);
         check_value("ack latency", DW'(2), DW'(lat));
      end
      report_test(5, "access timing", e0);

      finish_run();
   end

endmodule

/* la_wb_ram.f */
+incdir+logic
logic/la_mem_pkg.sv
logic/la_dpram.sv
logic/la_mem_clear.sv
logic/la_wb_ram_bridge.sv
logic/la_wb_ram.sv
dv/la_wb_ram_assert.sv
dv/la_wb_ram_tb.sv
